// ==== bench/exe_golden.txt ====
# name instr(hex) pc(hex) rd we result(hex) ex_valid ex_cause
# result is checked only when we is 1, ex_cause only when ex_valid is 1
lui_x1            123450B7 1000 1  1 0000000012345000 0 0
addi_fwd_lui      67808093 1004 1  1 0000000012345678 0 0
addi_neg_one      FFF00113 1008 2  1 FFFFFFFFFFFFFFFF 0 0
lui_sign_ext      800001B7 100C 3  1 FFFFFFFF80000000 0 0
addi_five         00500213 1010 4  1 0000000000000005 0 0
addi_neg_three    FFD00293 1014 5  1 FFFFFFFFFFFFFFFD 0 0
add               00408333 1018 6  1 000000001234567D 0 0
sub               405203B3 101C 7  1 0000000000000008 0 0
and               0020F433 1020 8  1 0000000012345678 0 0
or                0041E4B3 1024 9  1 FFFFFFFF80000005 0 0
xor               0020C533 1028 10 1 FFFFFFFFEDCBA987 0 0
slt_neg_pos       0042A5B3 102C 11 1 0000000000000001 0 0
sltu_big_small    0042B633 1030 12 1 0000000000000000 0 0
sltu_small_big    005236B3 1034 13 1 0000000000000001 0 0
addw_sign_ext     0030873B 1038 14 1 FFFFFFFF92345678 0 0
subw_neg          404007BB 103C 15 1 FFFFFFFFFFFFFFFB 0 0
sllw              0040983B 1040 16 1 00000000468ACF00 0 0
srlw              0041D8BB 1044 17 1 0000000004000000 0 0
sraw              4041D93B 1048 18 1 FFFFFFFFFC000000 0 0
addi_shamt_100    06400993 104C 19 1 0000000000000064 0 0
sll_mask6         01321A33 1050 20 1 0000005000000000 0 0
sllw_mask5        01321ABB 1054 21 1 0000000000000050 0 0
sra_mask6         4131DB33 1058 22 1 FFFFFFFFFFFFFFFF 0 0
srl_mask6         0131DBB3 105C 23 1 000000000FFFFFFF 0 0
srai_20           4141DC13 1060 24 1 FFFFFFFFFFFFF800 0 0
dep_base          00700C93 1064 25 1 0000000000000007 0 0
dep_dist1         001C8D13 1068 26 1 0000000000000008 0 0
dep_dist2         002C8D93 106C 27 1 0000000000000009 0 0
dep_dist3         01AC8E33 1070 28 1 000000000000000F 0 0
dep_mixed         41BE0EB3 1074 29 1 0000000000000006 0 0
illegal_mul       039C8D33 1078 26 0 0000000000000000 1 2
illegal_load      00002D03 107C 26 0 0000000000000000 1 2
read_after_ill    000D0F13 1080 30 1 0000000000000008 0 0
write_x0          00500013 1084 0  1 0000000000000005 0 0
read_x0           00400FB3 1088 31 1 0000000000000005 0 0

// ==== build.f ====
hdl/riscv_pkg.sv
hdl/drac_pkg.sv
hdl/wb_if.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/operand_read.sv
hdl/alu.sv
hdl/exe_cluster.sv
bench/exe_checker.sv
bench/tb_exe_cluster.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the exe_cluster testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_exe_cluster -f build.f -o sim_exe_cluster
./obj_dir/sim_exe_cluster | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== bench/tb_exe_cluster.sv ====
module tb_exe_cluster;

    logic        clk_i;
    logic        arst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [63:0] pc_i;
    logic        commit_valid_o;
    logic [63:0] commit_pc_o;
    logic [4:0]  commit_rd_o;
    logic        commit_we_o;
    logic [63:0] commit_result_o;
    logic        commit_ex_valid_o;
    logic [3:0]  commit_ex_cause_o;

    // Golden file fields.
    int          fd;
    int          n_fields;
    int          n_tests;
    int          bad_lines;
    int          wait_cycles;
    string       line;
    string       name;
    logic [31:0] g_instr;
    logic [63:0] g_pc;
    logic [63:0] g_result;
    int          g_rd;
    int          g_we;
    int          g_exv;
    int          g_cause;

    exe_cluster dut_i (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .pc_i              (pc_i),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .commit_rd_o       (commit_rd_o),
        .commit_we_o       (commit_we_o),
        .commit_result_o   (commit_result_o),
        .commit_ex_valid_o (commit_ex_valid_o),
        .commit_ex_cause_o (commit_ex_cause_o)
    );

    exe_checker chk_i (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .commit_valid_i    (commit_valid_o),
        .commit_pc_i       (commit_pc_o),
        .commit_rd_i       (commit_rd_o),
        .commit_we_i       (commit_we_o),
        .commit_result_i   (commit_result_o),
        .commit_ex_valid_i (commit_ex_valid_o),
        .commit_ex_cause_i (commit_ex_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus. One instruction per falling edge without gaps.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        n_tests       = 0;
        bad_lines     = 0;
        fd = $fopen("bench/exe_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/exe_golden.txt for reading");
        end
        repeat (2) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        while (fd != 0 && !$feof(fd)) begin
            line     = "";
            n_fields = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin    // Skip blanks and comments.
                n_fields = $sscanf(line, "%s %h %h %d %d %h %d %d", name, g_instr, g_pc,
                                   g_rd, g_we, g_result, g_exv, g_cause);
                if (n_fields == 8) begin
                    instr_valid_i = 1'b1;
                    instr_i       = g_instr;
                    pc_i          = g_pc;
                    chk_i.add_expect(name, g_pc, g_rd[4:0], g_we[0], g_result,
                                     g_exv[0], g_cause[3:0]);
                    n_tests++;
                    @(negedge clk_i);
                end else begin
                    $display("Golden file line could not be parsed: %s", line);
                    bad_lines++;
                end
            end
        end
        instr_valid_i = 1'b0;
        instr_i       = '0;
        if (fd != 0) begin
            $fclose(fd);
        end

        // Drain the pipe.
        for (wait_cycles = 0; wait_cycles < 200 && chk_i.pending() > 0; wait_cycles++) begin
            @(posedge clk_i);
        end

        // Trailing bubbles must not commit. The pipe is three stages deep.
        repeat (4) @(posedge clk_i);
        chk_i.report_totals();
        if (chk_i.fail_count == 0 && chk_i.pass_count == n_tests && n_tests > 0 &&
            bad_lines == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/exe_checker.sv ====
module exe_checker (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        commit_valid_i,
    input logic [63:0] commit_pc_i,
    input logic [4:0]  commit_rd_i,
    input logic        commit_we_i,
    input logic [63:0] commit_result_i,
    input logic        commit_ex_valid_i,
    input logic [3:0]  commit_ex_cause_i
);

    // Expected commits, oldest first.
    string       name_q [$];
    logic [63:0] pc_q [$];
    logic [4:0]  rd_q [$];
    logic        we_q [$];
    logic [63:0] result_q [$];
    logic        exv_q [$];
    logic [3:0]  cause_q [$];
    int          due_q [$];    // Cycle in which the commit must show.

    int cycle      = 0;
    int pass_count = 0;
    int fail_count = 0;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // Queue one expected commit. Pipeline latency is three cycles.
    task automatic add_expect(input string name, input logic [63:0] pc, input logic [4:0] rd,
                              input logic we, input logic [63:0] result, input logic exv,
                              input logic [3:0] cause);
        name_q.push_back(name);
        pc_q.push_back(pc);
        rd_q.push_back(rd);
        we_q.push_back(we);
        result_q.push_back(result);
        exv_q.push_back(exv);
        cause_q.push_back(cause);
        due_q.push_back(cycle + 3);
    endtask

    function automatic int pending();
        return name_q.size();
    endfunction

    task automatic report_mismatch(input string name, input string field,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("Mismatch in %s: %s expected %h actual %h", name, field, expected, actual);
        fail_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Commit compare, on the falling edge where outputs are settled.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_commit();
        string       name;
        logic [63:0] exp_pc;
        logic [4:0]  exp_rd;
        logic        exp_we;
        logic [63:0] exp_result;
        logic        exp_exv;
        logic [3:0]  exp_cause;
        int          due;
        if (name_q.size() == 0) begin
            $display("Unexpected commit at pc %h with no test waiting for it", commit_pc_i);
            fail_count++;
        end else begin
            name       = name_q.pop_front();
            exp_pc     = pc_q.pop_front();
            exp_rd     = rd_q.pop_front();
            exp_we     = we_q.pop_front();
            exp_result = result_q.pop_front();
            exp_exv    = exv_q.pop_front();
            exp_cause  = cause_q.pop_front();
            due        = due_q.pop_front();
            if (commit_pc_i !== exp_pc) begin
                report_mismatch(name, "pc", exp_pc, commit_pc_i);
            end else if (cycle != due) begin
                report_mismatch(name, "commit cycle", 64'(due), 64'(cycle));
            end else if (commit_rd_i !== exp_rd) begin
                report_mismatch(name, "rd", 64'(exp_rd), 64'(commit_rd_i));
            end else if (commit_we_i !== exp_we) begin
                report_mismatch(name, "we", 64'(exp_we), 64'(commit_we_i));
            end else if (exp_we && commit_result_i !== exp_result) begin
                report_mismatch(name, "result", exp_result, commit_result_i);
            end else if (commit_ex_valid_i !== exp_exv) begin
                report_mismatch(name, "ex_valid", 64'(exp_exv), 64'(commit_ex_valid_i));
            end else if (exp_exv && commit_ex_cause_i !== exp_cause) begin
                report_mismatch(name, "ex_cause", 64'(exp_cause), 64'(commit_ex_cause_i));
            end else begin
                $display("%s ok", name);
                pass_count++;
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (arst_n_i && commit_valid_i) begin
            check_commit();
        end
    end

    task automatic report_totals();
        if (name_q.size() != 0) begin
            $display("%0d expected commits never arrived before the timeout", name_q.size());
            fail_count += name_q.size();
        end
        $display("Tests run: %0d passed, %0d failed", pass_count, fail_count);
    endtask

endmodule

// ==== hdl/exe_cluster.sv ====
module exe_cluster (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  drac_pkg::bus64_t      pc_i,
    output logic                  commit_valid_o,
    output drac_pkg::bus64_t      commit_pc_o,
    output riscv_pkg::reg_addr_t  commit_rd_o,
    output logic                  commit_we_o,
    output drac_pkg::bus64_t      commit_result_o,
    output logic                  commit_ex_valid_o,
    output riscv_pkg::exc_cause_t commit_ex_cause_o
);
    import drac_pkg::*;

    id_rr_instr_t         decode;
    rr_exe_arith_instr_t  rr;
    exe_wb_scalar_instr_t exe;
    exe_wb_scalar_instr_t wb_q;
    logic                 wb_valid_q;
    bus64_t               rdata1;
    bus64_t               rdata2;

    wb_if fwd_exe ();      // Execute result, back to register read.
    wb_if wb_commit ();    // Writeback, into the register file.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stages.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    decoder decoder_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .decode_o      (decode)
    );

    regfile regfile_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rs1_i    (decode.rs1),    // Indices straight from decode.
        .rs2_i    (decode.rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wr       (wb_commit.cons)
    );

    operand_read operand_read_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .decode_i (decode),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .fwd      (fwd_exe.cons),
        .rr_o     (rr)
    );

    alu alu_i (
        .instruction_i (rr),
        .instruction_o (exe)
    );

    assign fwd_exe.valid = exe.valid;
    assign fwd_exe.we    = exe.regfile_we;
    assign fwd_exe.rd    = exe.rd;
    assign fwd_exe.data  = exe.result;

    // Writeback register. The regfile write lands at the end of this cycle.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= exe.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_q <= exe;
    end

    assign wb_commit.valid = wb_valid_q;
    assign wb_commit.we    = wb_q.regfile_we;
    assign wb_commit.rd    = wb_q.rd;
    assign wb_commit.data  = wb_q.result;

    assign commit_valid_o    = wb_valid_q;
    assign commit_pc_o       = wb_q.pc;
    assign commit_rd_o       = wb_q.rd;
    assign commit_we_o       = wb_q.regfile_we;
    assign commit_result_o   = wb_q.result;
    assign commit_ex_valid_o = wb_q.ex.valid;
    assign commit_ex_cause_o = wb_q.ex.cause;

endmodule

// ==== hdl/alu.sv ====
module alu (
    input  drac_pkg::rr_exe_arith_instr_t  instruction_i,    // From register read.
    output drac_pkg::exe_wb_scalar_instr_t instruction_o     // To writeback.
);
    import drac_pkg::*;
    import riscv_pkg::*;

    bus64_t      data_rs1;
    bus64_t      data_rs2;
    bus64_t      result;
    logic [31:0] word_res;    // Low half for the W forms.
    logic        is_word;

    assign data_rs1 = instruction_i.data_rs1;
    assign data_rs2 = instruction_i.data_rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        result   = '0;
        word_res = '0;
        is_word  = 1'b0;
        case (instruction_i.instr.instr_type)
            ADD:  result = data_rs1 + data_rs2;
            SUB:  result = data_rs1 - data_rs2;
            SLL:  result = data_rs1 << data_rs2[5:0];
            SLT:  result = {63'b0, $signed(data_rs1) < $signed(data_rs2)};
            SLTU: result = {63'b0, data_rs1 < data_rs2};
            XOR:  result = data_rs1 ^ data_rs2;
            SRL:  result = data_rs1 >> data_rs2[5:0];
            SRA:  result = $signed(data_rs1) >>> data_rs2[5:0];
            OR:   result = data_rs1 | data_rs2;
            AND:  result = data_rs1 & data_rs2;
            ADDW: begin
                is_word  = 1'b1;
                word_res = data_rs1[31:0] + data_rs2[31:0];
            end
            SUBW: begin
                is_word  = 1'b1;
                word_res = data_rs1[31:0] - data_rs2[31:0];
            end
            SLLW: begin
                is_word  = 1'b1;
                word_res = data_rs1[31:0] << data_rs2[4:0];
            end
            SRLW: begin
                is_word  = 1'b1;
                word_res = data_rs1[31:0] >> data_rs2[4:0];
            end
            SRAW: begin
                is_word  = 1'b1;
                word_res = $signed(data_rs1[31:0]) >>> data_rs2[4:0];
            end
            default: result = '0;    // NOP of an illegal instruction.
        endcase
        if (is_word) begin
            result = {{32{word_res[31]}}, word_res};    // Sign extend bit 31.
        end
    end

    // Trapping instructions still reach writeback so they can report.
    assign instruction_o.valid      = instruction_i.instr.valid &
                                      (instruction_i.instr.unit == UNIT_ALU |
                                       instruction_i.instr.ex.valid);
    assign instruction_o.pc         = instruction_i.instr.pc;
    assign instruction_o.rd         = instruction_i.instr.rd;
    assign instruction_o.regfile_we = instruction_i.instr.regfile_we;
    assign instruction_o.instr_type = instruction_i.instr.instr_type;
    assign instruction_o.result     = result;
    assign instruction_o.ex         = instruction_i.instr.ex;

endmodule

// ==== hdl/operand_read.sv ====
module operand_read (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  drac_pkg::id_rr_instr_t        decode_i,
    input  drac_pkg::bus64_t              rdata1_i,
    input  drac_pkg::bus64_t              rdata2_i,
    wb_if.cons                            fwd,
    output drac_pkg::rr_exe_arith_instr_t rr_o
);
    import drac_pkg::*;

    logic                fwd_ok;
    logic                hit_rs1;
    logic                hit_rs2;
    rr_exe_arith_instr_t rr_d;
    rr_exe_arith_instr_t rr_q;
    logic                valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand select. The execute stage is younger than writeback and wins.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fwd_ok  = fwd.valid && fwd.we && (fwd.rd != '0);
    assign hit_rs1 = fwd_ok && (fwd.rd == decode_i.rs1);
    assign hit_rs2 = fwd_ok && (fwd.rd == decode_i.rs2);

    always_comb begin
        rr_d.instr    = decode_i;
        rr_d.data_rs1 = hit_rs1 ? fwd.data : rdata1_i;
        if (decode_i.use_imm) begin
            rr_d.data_rs2 = decode_i.imm;
        end else begin
            rr_d.data_rs2 = hit_rs2 ? fwd.data : rdata2_i;
        end
    end

    // Read-to-execute register.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= decode_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        rr_q <= rr_d;
    end

    always_comb begin
        rr_o             = rr_q;
        rr_o.instr.valid = valid_q;
    end

endmodule

// ==== hdl/regfile.sv ====
module regfile (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  riscv_pkg::reg_addr_t rs1_i,
    input  riscv_pkg::reg_addr_t rs2_i,
    output drac_pkg::bus64_t     rdata1_o,
    output drac_pkg::bus64_t     rdata2_o,
    wb_if.cons                   wr
);
    import drac_pkg::*;
    import riscv_pkg::*;

    bus64_t regs_q [1:31];    // No storage behind x0.
    logic   wr_en;

    assign wr_en = wr.valid && wr.we && (wr.rd != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr.rd] <= wr.data;
        end
    end

    // One read port. A write in the same cycle is seen right away.
    function automatic bus64_t read_port(input reg_addr_t idx);
        bus64_t data;
        if (idx == '0) begin
            data = '0;
        end else if (wr_en && wr.rd == idx) begin
            data = wr.data;
        end else begin
            data = regs_q[idx];
        end
        return data;
    endfunction

    always_comb begin
        rdata1_o = read_port(rs1_i);
        rdata2_o = read_port(rs2_i);
    end

endmodule

// ==== hdl/decoder.sv ====
module decoder (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    input  drac_pkg::bus64_t       pc_i,
    output drac_pkg::id_rr_instr_t decode_o
);
    import drac_pkg::*;
    import riscv_pkg::*;

    opcode_t      opcode;
    logic [2:0]   funct3;
    logic         f7_base;
    logic         f7_alt;
    logic         sh_base;    // RV64 immediate shifts use a 6-bit shamt.
    logic         sh_alt;
    logic         alt_ok;
    logic         illegal;
    id_rr_instr_t dec_d;
    id_rr_instr_t dec_q;
    logic         valid_q;

    assign opcode  = opcode_t'(instr_i[6:0]);
    assign funct3  = instr_i[14:12];
    assign f7_base = (instr_i[31:25] == F7_BASE);
    assign f7_alt  = (instr_i[31:25] == F7_ALT);
    assign sh_base = (instr_i[31:26] == 6'b000000);
    assign sh_alt  = (instr_i[31:26] == 6'b010000);
    assign alt_ok  = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);

    function automatic instr_type_t op_type(input logic [2:0] f3, input logic alt);
        instr_type_t t;
        case (f3)
            F3_ADD_SUB: t = alt ? SUB : ADD;
            F3_SLL:     t = SLL;
            F3_SLT:     t = SLT;
            F3_SLTU:    t = SLTU;
            F3_XOR:     t = XOR;
            F3_SRL_SRA: t = alt ? SRA : SRL;
            F3_OR:      t = OR;
            default:    t = AND;
        endcase
        return t;
    endfunction

    // NOP marks a funct3 with no W form.
    function automatic instr_type_t word_type(input logic [2:0] f3, input logic alt);
        instr_type_t t;
        case (f3)
            F3_ADD_SUB: t = alt ? SUBW : ADDW;
            F3_SLL:     t = SLLW;
            F3_SRL_SRA: t = alt ? SRAW : SRLW;
            default:    t = NOP;
        endcase
        return t;
    endfunction

    always_comb begin
        dec_d.valid      = instr_valid_i;
        dec_d.pc         = pc_i;
        dec_d.unit       = UNIT_ALU;
        dec_d.instr_type = NOP;
        dec_d.rs1        = instr_i[19:15];
        dec_d.rs2        = instr_i[24:20];
        dec_d.rd         = instr_i[11:7];
        dec_d.use_imm    = 1'b0;
        dec_d.imm        = {{52{instr_i[31]}}, instr_i[31:20]};    // I-type.
        dec_d.regfile_we = 1'b1;
        illegal          = 1'b0;
        case (opcode)
            LUI: begin
                dec_d.instr_type = ADD;
                dec_d.rs1        = '0;    // Upper immediate plus x0.
                dec_d.use_imm    = 1'b1;
                dec_d.imm        = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
            end
            OP: begin
                dec_d.instr_type = op_type(funct3, f7_alt);
                illegal          = !(f7_base || (f7_alt && alt_ok));
            end
            OP_IMM: begin
                dec_d.use_imm    = 1'b1;
                dec_d.instr_type = op_type(funct3, sh_alt && funct3 == F3_SRL_SRA);
                illegal          = (funct3 == F3_SLL && !sh_base) ||
                                   (funct3 == F3_SRL_SRA && !(sh_base || sh_alt));
            end
            OP_32: begin
                dec_d.instr_type = word_type(funct3, f7_alt);
                illegal          = (dec_d.instr_type == NOP) ||
                                   !(f7_base || (f7_alt && alt_ok));
            end
            OP_IMM_32: begin
                dec_d.use_imm    = 1'b1;
                dec_d.instr_type = word_type(funct3, f7_alt && funct3 == F3_SRL_SRA);
                illegal          = (dec_d.instr_type == NOP) ||
                                   (funct3 != F3_ADD_SUB &&
                                    !(f7_base || (f7_alt && funct3 == F3_SRL_SRA)));
            end
            default: illegal = 1'b1;
        endcase

        // Unknown encodings travel as a NOP that only raises the exception.
        if (illegal) begin
            dec_d.unit       = UNIT_NONE;
            dec_d.instr_type = NOP;
            dec_d.regfile_we = 1'b0;
        end
        dec_d.ex.valid  = illegal;
        dec_d.ex.cause  = illegal ? ILLEGAL_INSTR : INSTR_ADDR_MISALIGNED;
        dec_d.ex.origin = {32'b0, instr_i};
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_q <= dec_d;
    end

    always_comb begin
        decode_o       = dec_q;
        decode_o.valid = valid_q;
    end

endmodule

// ==== hdl/wb_if.sv ====
interface wb_if;
    import drac_pkg::*;
    import riscv_pkg::*;

    logic      valid;    // A result is present.
    logic      we;       // It targets the register file.
    reg_addr_t rd;
    bus64_t    data;

    // rd and data only count while valid and we are both high.
    modport prod (output valid, we, rd, data);
    modport cons (input valid, we, rd, data);

endinterface

// ==== hdl/drac_pkg.sv ====
package drac_pkg;

    typedef logic [63:0] bus64_t;    // Native data word.

    // Operation carried down the pipe. Immediate forms share these.
    typedef enum logic [4:0] {
        ADD, ADDW, SUB, SUBW,
        SLL, SLLW, SLT, SLTU,
        XOR, SRL, SRLW, SRA,
        SRAW, OR, AND, NOP
    } instr_type_t;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU
    } unit_t;

    typedef struct packed {
        logic                  valid;
        riscv_pkg::exc_cause_t cause;
        bus64_t                origin;    // Raw instruction, zero extended.
    } exception_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                 valid;
        bus64_t               pc;
        unit_t                unit;
        instr_type_t          instr_type;
        riscv_pkg::reg_addr_t rs1;
        riscv_pkg::reg_addr_t rs2;
        riscv_pkg::reg_addr_t rd;
        logic                 use_imm;     // Second operand is imm.
        bus64_t               imm;
        logic                 regfile_we;
        exception_t           ex;
    } id_rr_instr_t;

    typedef struct packed {
        id_rr_instr_t instr;
        bus64_t       data_rs1;
        bus64_t       data_rs2;    // Already holds imm when use_imm is set.
    } rr_exe_arith_instr_t;

    typedef struct packed {
        logic                 valid;
        bus64_t               pc;
        riscv_pkg::reg_addr_t rd;
        logic                 regfile_we;
        instr_type_t          instr_type;
        bus64_t               result;
        exception_t           ex;
    } exe_wb_scalar_instr_t;

endpackage

// ==== hdl/riscv_pkg.sv ====
package riscv_pkg;

    typedef logic [4:0] reg_addr_t;    // Architectural register index.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes of the integer groups this slice executes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        LUI       = 7'b0110111,
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011
    } opcode_t;

    // Function fields shared by the register and immediate forms.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;    // SUB and SRA variants.

    // Exception causes as numbered by the privileged spec.
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2
    } exc_cause_t;

endpackage
